// ==== bench/ahbSlaveModel.sv ====
`timescale 1ns/1ps

// single-transfer AHB-Lite slave serving the bus region with random wait states
module ahbSlaveModel (
  input  logic             clk,
  input  logic             rst,
  input  lsuPkg::adrT      HADDR,
  input  logic             HWRITE,
  input  logic [1:0]       HTRANS,
  input  lsuPkg::wordT     HWDATA,
  input  lsuPkg::byteMaskT HWSTRB,
  output lsuPkg::wordT     HRDATA,
  output logic             HREADY
);
  import lsuPkg::*;

  wordT       mem [busSpan/4];
  integer     seed;
  logic       active;
  logic       writeReg;
  logic [9:0] wordIdx;
  logic [1:0] waitLeft;

  initial begin
    seed = 32'ha39;
    // every word starts out holding a value derived from its own address
    for (int i = 0; i < busSpan/4; i++) begin
      mem[i] = (busBase + 4 * i) ^ 32'hc3c3_5a5a;
    end
  end

  // ready is high when idle and once the wait states have run out
  assign HREADY = !active || (waitLeft == 2'd0);
  assign HRDATA = active ? mem[wordIdx] : '0;

  always @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      waitLeft <= 2'd0;
    end else begin
      if (active && HREADY) begin
        // the data phase ends here, HWDATA is valid in this cycle
        if (writeReg) begin
          for (int i = 0; i < 4; i++) begin
            if (HWSTRB[i]) begin
              mem[wordIdx][8*i +: 8] <= HWDATA[8*i +: 8];
            end
          end
        end
        active <= 1'b0;
      end else if (active) begin
        waitLeft <= waitLeft - 2'd1;
      end
      // accept an address phase and draw 0 to 2 wait states for it
      if ((HTRANS == htransNonseq) && HREADY) begin
        active   <= 1'b1;
        writeReg <= HWRITE;
        wordIdx  <= HADDR[11:2];
        waitLeft <= {$random(seed)} % 3;
      end
    end
  end

endmodule

// ==== bench/lsuTb.sv ====
`timescale 1ns/1ps

module lsuTb;
  import lsuPkg::*;

  localparam funct3T f3Byte  = 3'b000;
  localparam funct3T f3Half  = 3'b001;
  localparam funct3T f3Word  = 3'b010;
  localparam funct3T f3ByteU = 3'b100;
  localparam funct3T f3HalfU = 3'b101;

  // each fault output has its own code in the table
  localparam logic [2:0] faultNone     = 3'd0;
  localparam logic [2:0] faultLoadMis  = 3'd1;
  localparam logic [2:0] faultStoreMis = 3'd2;
  localparam logic [2:0] faultLoadAcc  = 3'd3;
  localparam logic [2:0] faultStoreAcc = 3'd4;
  localparam time        driveDelay    = 2;

  typedef struct packed {
    memRwT      rw;
    funct3T     f3;
    adrT        adr;
    wordT       wdata;
    logic       be;
    wordT       expData;
    logic [2:0] expFault;
  } rowT;

  logic     clk;
  logic     rst;
  logic     StallM;
  logic     StallW;
  memRwT    MemRWM;
  funct3T   Funct3M;
  adrT      IEUAdrE;
  wordT     WriteDataM;
  logic     BigEndianM;
  adrT      IEUAdrM;
  wordT     ReadDataW;
  logic     LSUStallM;
  logic     CommittedM;
  logic     LoadMisalignedFaultM;
  logic     StoreMisalignedFaultM;
  logic     LoadAccessFaultM;
  logic     StoreAccessFaultM;
  adrT      HADDR;
  logic     HWRITE;
  logic [2:0] HSIZE;
  logic [1:0] HTRANS;
  wordT     HWDATA;
  byteMaskT HWSTRB;
  wordT     HRDATA;
  logic     HREADY;

  rowT  rows [$];
  wordT shadow [adrT];
  int   errorCount = 0;
  int   checkCount = 0;
  int   cycleCount = 0;
  int   cycleLimit = 1000;
  logic rowOk;

  // the bench stands in for the pipeline, so M and W stall with the LSU
  assign StallM = LSUStallM;
  assign StallW = StallM;

  lsu dut_i (
    .clk(clk), .rst(rst), .StallM(StallM), .StallW(StallW),
    .MemRWM(MemRWM), .Funct3M(Funct3M), .IEUAdrE(IEUAdrE), .WriteDataM(WriteDataM),
    .BigEndianM(BigEndianM), .IEUAdrM(IEUAdrM), .ReadDataW(ReadDataW),
    .LSUStallM(LSUStallM), .CommittedM(CommittedM),
    .LoadMisalignedFaultM(LoadMisalignedFaultM), .StoreMisalignedFaultM(StoreMisalignedFaultM),
    .LoadAccessFaultM(LoadAccessFaultM), .StoreAccessFaultM(StoreAccessFaultM),
    .HADDR(HADDR), .HWRITE(HWRITE), .HSIZE(HSIZE), .HTRANS(HTRANS), .HWDATA(HWDATA),
    .HWSTRB(HWSTRB), .HRDATA(HRDATA), .HREADY(HREADY)
  );

  ahbSlaveModel slave_i (
    .clk(clk), .rst(rst), .HADDR(HADDR), .HWRITE(HWRITE), .HTRANS(HTRANS),
    .HWDATA(HWDATA), .HWSTRB(HWSTRB), .HRDATA(HRDATA), .HREADY(HREADY)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // an access takes at most six cycles, so this only trips on a hang
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout after %0d cycles, an access never completed", cycleCount);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic wordT reverseBytes(input wordT w);
    wordT r;
    for (int i = 0; i < 4; i++)
      r[8*i +: 8] = w[8*(3-i) +: 8];
    return r;
  endfunction

  // replicate, reverse for big-endian, then merge only the addressed lanes
  function automatic wordT mergeStore(input wordT old, input funct3T f3, input logic [1:0] off,
                                      input wordT data, input logic be);
    wordT       img;
    logic [3:0] lanes;
    wordT       result;
    case (f3[1:0])
      2'b00:   img = {4{data[7:0]}};
      2'b01:   img = {2{data[15:0]}};
      default: img = data;
    endcase
    if (be)
      img = reverseBytes(img);
    case (f3[1:0])
      2'b00:   lanes = 4'b0001 << off;
      2'b01:   lanes = 4'b0011 << off;
      default: lanes = 4'b1111;
    endcase
    result = old;
    for (int i = 0; i < 4; i++)
      if (lanes[i])
        result[8*i +: 8] = img[8*i +: 8];
    return result;
  endfunction

  // reverse first for big-endian, then shift the addressed lane down and extend
  function automatic wordT loadValue(input funct3T f3, input logic [1:0] off,
                                     input wordT raw, input logic be);
    wordT w;
    wordT shifted;
    w = be ? reverseBytes(raw) : raw;
    shifted = w >> (8 * off);
    case (f3[1:0])
      2'b00:   return f3[2] ? {24'b0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
      2'b01:   return f3[2] ? {16'b0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
      default: return w;
    endcase
  endfunction

  // misalignment wins over an address outside both regions
  function automatic logic [2:0] expectFault(input memRwT rw, input funct3T f3, input adrT adr);
    logic badAlign;
    logic inMap;
    // an access of 2**n bytes needs its low n address bits clear
    badAlign = (adr & ((adrT'(1) << f3[1:0]) - adrT'(1))) != '0;
    inMap = (adr < dtimBase + dtimWords * 4) ||
            ((adr >= busBase) && (adr < busBase + busSpan));
    if (rw == memNone)
      return faultNone;
    if (badAlign)
      return (rw == memRead) ? faultLoadMis : faultStoreMis;
    if (!inMap)
      return (rw == memRead) ? faultLoadAcc : faultStoreAcc;
    return faultNone;
  endfunction

  function automatic logic [2:0] faultCode();
    case ({LoadMisalignedFaultM, StoreMisalignedFaultM, LoadAccessFaultM, StoreAccessFaultM})
      4'b0000: return faultNone;
      4'b1000: return faultLoadMis;
      4'b0100: return faultStoreMis;
      4'b0010: return faultLoadAcc;
      4'b0001: return faultStoreAcc;
      default: return 3'd7;
    endcase
  endfunction

  // the shadow memory runs ahead while the table is built
  task automatic addRow(input memRwT rw, input funct3T f3, input adrT adr,
                        input wordT wdata, input logic be);
    rowT r;
    adrT key;
    key = {adr[31:2], 2'b00};
    r = '{rw: rw, f3: f3, adr: adr, wdata: wdata, be: be, expData: 'x, expFault: faultNone};
    r.expFault = expectFault(rw, f3, adr);
    if (r.expFault == faultNone) begin
      if (rw == memWrite)
        shadow[key] = mergeStore(shadow.exists(key) ? shadow[key] : 'x, f3, adr[1:0], wdata, be);
      else if (shadow.exists(key))
        r.expData = loadValue(f3, adr[1:0], shadow[key], be);
    end
    rows.push_back(r);
  endtask

  task automatic buildTable();
    // DTIM word round trip, including the last word of the region
    addRow(memWrite, f3Word, 32'h0000_0000, 32'h1234_5678, 1'b0);
    addRow(memWrite, f3Word, 32'h0000_03fc, 32'hcafe_f00d, 1'b0);
    addRow(memRead,  f3Word, 32'h0000_0000, 32'h0, 1'b0);
    addRow(memRead,  f3Word, 32'h0000_03fc, 32'h0, 1'b0);
    // DTIM subwords at every legal offset
    addRow(memWrite, f3Word, 32'h0000_0010, 32'h0000_0000, 1'b0);
    addRow(memWrite, f3Byte, 32'h0000_0010, 32'h0000_00a1, 1'b0);
    addRow(memWrite, f3Byte, 32'h0000_0011, 32'h0000_00b2, 1'b0);
    addRow(memWrite, f3Byte, 32'h0000_0013, 32'h0000_00f4, 1'b0);
    addRow(memWrite, f3Half, 32'h0000_0012, 32'h0000_8765, 1'b0);
    addRow(memRead,  f3Byte,  32'h0000_0013, 32'h0, 1'b0);
    addRow(memRead,  f3ByteU, 32'h0000_0013, 32'h0, 1'b0);
    addRow(memRead,  f3Byte,  32'h0000_0010, 32'h0, 1'b0);
    addRow(memRead,  f3Half,  32'h0000_0012, 32'h0, 1'b0);
    addRow(memRead,  f3HalfU, 32'h0000_0010, 32'h0, 1'b0);
    addRow(memRead,  f3Word,  32'h0000_0010, 32'h0, 1'b0);
    // bus region under random wait states
    addRow(memWrite, f3Word, 32'h8000_0020, 32'h5a5a_5a5a, 1'b0);
    addRow(memWrite, f3Byte, 32'h8000_0021, 32'h0000_0099, 1'b0);
    addRow(memWrite, f3Half, 32'h8000_0022, 32'h0000_beef, 1'b0);
    addRow(memRead,  f3Byte,  32'h8000_0021, 32'h0, 1'b0);
    addRow(memRead,  f3Half,  32'h8000_0022, 32'h0, 1'b0);
    addRow(memRead,  f3HalfU, 32'h8000_0022, 32'h0, 1'b0);
    addRow(memRead,  f3Word,  32'h8000_0020, 32'h0, 1'b0);
    addRow(memWrite, f3Word, 32'h8000_0ffc, 32'h0f1e_2d3c, 1'b0);
    addRow(memRead,  f3Word, 32'h8000_0ffc, 32'h0, 1'b0);
    // big-endian on both paths
    addRow(memWrite, f3Word, 32'h0000_0020, 32'h1122_3344, 1'b1);
    addRow(memRead,  f3Word, 32'h0000_0020, 32'h0, 1'b0);
    addRow(memRead,  f3Word, 32'h0000_0020, 32'h0, 1'b1);
    addRow(memWrite, f3Half, 32'h0000_0020, 32'h0000_a1b2, 1'b1);
    addRow(memRead,  f3HalfU, 32'h0000_0022, 32'h0, 1'b1);
    addRow(memRead,  f3Word, 32'h8000_0020, 32'h0, 1'b1);
    // faults, then proof that memory kept its contents
    addRow(memWrite, f3Word, 32'h0000_0002, 32'hffff_ffff, 1'b0);
    addRow(memRead,  f3Half, 32'h8000_0023, 32'h0, 1'b0);
    addRow(memRead,  f3Word, 32'h0000_1000, 32'h0, 1'b0);
    addRow(memWrite, f3Byte, 32'h4000_0000, 32'h0000_0055, 1'b0);
    addRow(memWrite, f3Half, 32'h8000_0021, 32'h0000_ffff, 1'b0);
    addRow(memRead,  f3Word, 32'h0000_0000, 32'h0, 1'b0);
    addRow(memRead,  f3Word, 32'h8000_0020, 32'h0, 1'b0);
  endtask

  ////////////////////
  // checks and driver
  ////////////////////

  task automatic checkValue(input string name, input wordT got, input wordT exp);
    checkCount++;
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      errorCount++;
      rowOk = 1'b0;
    end
  endtask

  task automatic checkTrue(input logic cond, input string what);
    checkCount++;
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      errorCount++;
      rowOk = 1'b0;
    end
  endtask

  task automatic applyRow(input rowT r, input int idx);
    int         stallCycles;
    int         committedCycles;
    logic [2:0] seenFault;
    logic       onBus;
    rowOk = 1'b1;
    stallCycles = 0;
    committedCycles = 0;
    onBus = (r.expFault == faultNone) && (r.adr >= busBase);
    // in the E cycle the address goes in while M holds no access
    MemRWM  = memNone;
    IEUAdrE = r.adr;
    @(negedge clk);
    checkTrue(!LSUStallM && (HTRANS == htransIdle), "the previous access still held the bus");
    @(posedge clk);
    #driveDelay;
    // the M cycle is held until LSUStallM drops
    MemRWM     = r.rw;
    Funct3M    = r.f3;
    WriteDataM = r.wdata;
    BigEndianM = r.be;
    @(negedge clk);
    seenFault = faultCode();
    checkValue("IEUAdrM", IEUAdrM, r.adr);
    // a bus access puts its address phase out in the first M cycle
    if (onBus) begin
      checkTrue(HTRANS == htransNonseq, "no address phase in the first M cycle of a bus access");
      checkValue("HADDR", HADDR, r.adr);
      checkValue("HWRITE", wordT'(HWRITE), wordT'(r.rw == memWrite));
      checkValue("HSIZE", wordT'(HSIZE), wordT'(r.f3[1:0]));
    end else begin
      checkTrue(HTRANS == htransIdle, "address phase issued for an access off the bus");
    end
    while (LSUStallM) begin
      stallCycles++;
      if (CommittedM)
        committedCycles++;
      @(negedge clk);
    end
    if (CommittedM)
      committedCycles++;
    @(posedge clk);
    #driveDelay;
    checkValue("fault code", wordT'(seenFault), wordT'(r.expFault));
    if ((r.rw == memRead) && (r.expFault == faultNone))
      checkValue("ReadDataW", ReadDataW, r.expData);
    // the idle cycle stalls without commit while Data and Done are both committed
    if (onBus) begin
      checkTrue(stallCycles >= 2, "bus access ended in fewer than two stall cycles");
      checkTrue(committedCycles == stallCycles, "CommittedM did not cover the transfer");
    end else begin
      checkTrue(stallCycles == 0, "LSUStallM rose without a bus access");
      checkTrue(committedCycles == 0, "CommittedM rose without a bus access");
    end
    $display("row %0d %s f3=%03b adr=%h be=%0d stalls=%0d %s", idx,
             (r.rw == memRead) ? "load" : "store", r.f3, r.adr, r.be, stallCycles,
             rowOk ? "ok" : "FAILED");
  endtask

  initial begin
    rst        = 1'b1;
    MemRWM     = memNone;
    Funct3M    = f3Word;
    IEUAdrE    = '0;
    WriteDataM = '0;
    BigEndianM = 1'b0;
    buildTable();
    cycleLimit = rows.size() * 8 + 20;
    repeat (2) @(posedge clk);
    #driveDelay;
    rst = 1'b0;
    foreach (rows[i])
      applyRow(rows[i], i);
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checkCount, errorCount);
    if (errorCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== bench/lsu_asserts.sv ====
`timescale 1ns/1ps

module lsu_asserts (
  input logic        clk,
  input logic        rst,
  input logic [1:0]  HTRANS,
  input logic        HREADY,
  input lsuPkg::adrT HADDR,
  input logic        HWRITE,
  input logic        LSUStallM,
  input logic        LoadMisalignedFaultM,
  input logic        StoreMisalignedFaultM,
  input logic        LoadAccessFaultM,
  input logic        StoreAccessFaultM
);
  import lsuPkg::*;

  logic anyFault;

  assign anyFault = LoadMisalignedFaultM || StoreMisalignedFaultM ||
                    LoadAccessFaultM || StoreAccessFaultM;

  // the first cycle out of reset leaves both the bus and the pipeline quiet
  resetQuiet: assert property (@(posedge clk)
    $fell(rst) |-> (HTRANS == htransIdle) && !LSUStallM)
    else $error("bus or stall active in the first cycle after reset");

  // an address phase that is not yet accepted must not move
  addrHeld: assert property (@(posedge clk) disable iff (rst)
    (HTRANS == htransNonseq) && !HREADY |=> $stable(HADDR) && $stable(HWRITE))
    else $error("address phase changed while HREADY was low");

  // a faulted access never reaches the bus
  noFaultTransfer: assert property (@(posedge clk) disable iff (rst)
    !((HTRANS == htransNonseq) && anyFault))
    else $error("bus transfer started for a faulted access");

endmodule

// attach the checks to every lsu instance
bind lsu lsu_asserts asserts_i (
  .clk(clk), .rst(rst), .HTRANS(HTRANS), .HREADY(HREADY), .HADDR(HADDR),
  .HWRITE(HWRITE), .LSUStallM(LSUStallM),
  .LoadMisalignedFaultM(LoadMisalignedFaultM), .StoreMisalignedFaultM(StoreMisalignedFaultM),
  .LoadAccessFaultM(LoadAccessFaultM), .StoreAccessFaultM(StoreAccessFaultM)
);

// ==== build.f ====
hdl/lsuPkg.sv
hdl/memReqIf.sv
hdl/subwordUnit.sv
hdl/dtim.sv
hdl/ahbMaster.sv
hdl/lsu.sv
bench/ahbSlaveModel.sv
bench/lsu_asserts.sv
bench/lsuTb.sv

// ==== hdl/ahbMaster.sv ====
`timescale 1ns/1ps

module ahbMaster (
  input  logic             clk,
  input  logic             rst,
  input  logic             StallM,
  memReqIf.busPort         req,
  output logic             committed,
  // AHB-Lite master side
  output lsuPkg::adrT      HADDR,
  output logic             HWRITE,
  output logic [2:0]       HSIZE,
  output logic [1:0]       HTRANS,
  output lsuPkg::wordT     HWDATA,
  output lsuPkg::byteMaskT HWSTRB,
  input  lsuPkg::wordT     HRDATA,
  input  logic             HREADY
);
  import lsuPkg::*;

  busStateT state;
  busStateT nextState;
  logic     request;
  logic     addrAccepted;
  logic     dataDone;
  wordT     readBuf;

  // any nonzero rw from the LSU is a request for one transfer
  assign request = (req.rw != memNone);

  // the address phase ends on the first edge with HREADY high
  assign addrAccepted = (state == Idle) && request && HREADY;
  assign dataDone     = (state == Data) && HREADY;

  ////////////////////
  // FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      Idle: if (addrAccepted) nextState = Data;
      Data: if (dataDone) nextState = Done;
      // stay put while the rest of the pipeline holds the instruction in M
      Done: if (!StallM) nextState = Idle;
      default: nextState = Idle;
    endcase
  end

  // stall starts in the same cycle the request appears, no edge needed
  assign req.stall = ((state == Idle) && request) || (state == Data);

  // once the address is out the access can no longer be abandoned
  assign committed = (state == Data) || (state == Done);

  ////////////////////
  // address phase
  ////////////////////

  // the request fields are held by the LSU while stall is high
  assign HTRANS = ((state == Idle) && request) ? htransNonseq : htransIdle;
  assign HADDR  = req.adr;
  assign HWRITE = req.rw[0];
  assign HSIZE  = {1'b0, req.size[1:0]};

  ////////////////////
  // data phase
  ////////////////////

  // write data trails the address by one phase, as AHB requires
  always_ff @(posedge clk) begin
    if (addrAccepted) begin
      HWDATA <= req.writeData;
      HWSTRB <= req.byteMask;
    end
  end

  // the buffer keeps the loaded word steady through Done
  always_ff @(posedge clk) begin
    if (dataDone) begin
      readBuf <= HRDATA;
    end
  end

  assign req.readData = readBuf;

endmodule

// ==== hdl/dtim.sv ====
`timescale 1ns/1ps

module dtim (
  input  logic      clk,
  input  logic      StallM,
  memReqIf.dtimPort req
);
  import lsuPkg::*;

  // word array, no reset since it holds data only
  wordT                   mem [dtimWords];
  wordT                   readReg;
  logic [dtimAdrBits-1:0] wordIdx;

  // the region is word addressed, byte offset comes from the byte mask
  assign wordIdx = req.adr[dtimAdrBits+1:2];

  ////////////////////
  // read port
  ////////////////////

  // reads use the execute-stage address so the word is ready in the M stage
  // holding the register under stall keeps ReadDataM constant for the CPU
  always_ff @(posedge clk) begin
    if (!StallM) begin
      readReg <= mem[wordIdx];
    end
  end

  assign req.readData = readReg;

  ////////////////////
  // write port
  ////////////////////

  // a store lands on the edge that lets the instruction leave M
  always_ff @(posedge clk) begin
    if (req.rw[0] && !StallM) begin
      for (int i = 0; i < xLen/8; i++) begin
        // only the enabled lanes change
        if (req.byteMask[i]) begin
          mem[wordIdx][8*i +: 8] <= req.writeData[8*i +: 8];
        end
      end
    end
  end

endmodule

// ==== hdl/lsu.sv ====
`timescale 1ns/1ps

module lsu (
  input  logic             clk,
  input  logic             rst,
  input  logic             StallM,
  input  logic             StallW,
  // cpu side
  input  lsuPkg::memRwT    MemRWM,
  input  lsuPkg::funct3T   Funct3M,
  input  lsuPkg::adrT      IEUAdrE,
  input  lsuPkg::wordT     WriteDataM,
  input  logic             BigEndianM,
  output lsuPkg::adrT      IEUAdrM,
  output lsuPkg::wordT     ReadDataW,
  output logic             LSUStallM,
  output logic             CommittedM,
  // faults to the trap logic
  output logic             LoadMisalignedFaultM,
  output logic             StoreMisalignedFaultM,
  output logic             LoadAccessFaultM,
  output logic             StoreAccessFaultM,
  // AHB-Lite
  output lsuPkg::adrT      HADDR,
  output logic             HWRITE,
  output logic [2:0]       HSIZE,
  output logic [1:0]       HTRANS,
  output lsuPkg::wordT     HWDATA,
  output lsuPkg::byteMaskT HWSTRB,
  input  lsuPkg::wordT     HRDATA,
  input  logic             HREADY
);
  import lsuPkg::*;

  logic     isLoad;
  logic     isStore;
  logic     selDtim;
  logic     selBus;
  logic     misaligned;
  logic     outOfRegion;
  wordT     storeWord;
  byteMaskT byteMask;
  wordT     rawReadWord;
  wordT     loadData;

  memReqIf dtimReq ();
  memReqIf busReq ();

  ////////////////////
  // address and control
  ////////////////////

  // E to M address register, it follows the pipeline stall
  always_ff @(posedge clk) begin
    if (rst) begin
      IEUAdrM <= '0;
    end else if (!StallM) begin
      IEUAdrM <= IEUAdrE;
    end
  end

  assign isLoad  = (MemRWM == memRead);
  assign isStore = (MemRWM == memWrite);

  // region decode in place of a PMA check
  assign selDtim     = (IEUAdrM - dtimBase) < adrT'(dtimWords * 4);
  assign selBus      = (IEUAdrM - busBase) < adrT'(busSpan);
  assign outOfRegion = !selDtim && !selBus;

  // halves must be even and words must sit on a four-byte boundary
  assign misaligned = ((Funct3M[1:0] == 2'b01) && IEUAdrM[0]) ||
                      ((Funct3M[1:0] == 2'b10) && (IEUAdrM[1:0] != 2'b00));

  // Misalignment outranks the access fault, so only one fault shows per access.
  assign LoadMisalignedFaultM  = isLoad && misaligned;
  assign StoreMisalignedFaultM = isStore && misaligned;
  assign LoadAccessFaultM      = isLoad && outOfRegion && !misaligned;
  assign StoreAccessFaultM     = isStore && outOfRegion && !misaligned;

  ////////////////////
  // memory system
  ////////////////////

  // a faulted access reaches neither port
  assign dtimReq.rw        = (selDtim && !misaligned) ? MemRWM : memNone;
  // loads read ahead with the E address, stores write with the M address
  assign dtimReq.adr       = dtimReq.rw[0] ? IEUAdrM : IEUAdrE;
  assign dtimReq.size      = Funct3M;
  assign dtimReq.writeData = storeWord;
  assign dtimReq.byteMask  = byteMask;

  assign busReq.rw        = (selBus && !misaligned) ? MemRWM : memNone;
  assign busReq.adr       = IEUAdrM;
  assign busReq.size      = Funct3M;
  assign busReq.writeData = storeWord;
  assign busReq.byteMask  = byteMask;

  dtim dtim_i (
    .clk    (clk),
    .StallM (StallM),
    .req    (dtimReq.dtimPort)
  );

  ahbMaster ahbMaster_i (
    .clk       (clk),
    .rst       (rst),
    .StallM    (StallM),
    .req       (busReq.busPort),
    .committed (CommittedM),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HTRANS    (HTRANS),
    .HWDATA    (HWDATA),
    .HWSTRB    (HWSTRB),
    .HRDATA    (HRDATA),
    .HREADY    (HREADY)
  );

  // only the bus can hold the pipeline, the DTIM always answers in one cycle
  assign LSUStallM = busReq.stall;

  // pick the raw word from whichever port the address decoded to
  assign rawReadWord = selDtim ? dtimReq.readData : busReq.readData;

  ////////////////////
  // subword datapath
  ////////////////////

  subwordUnit subwordUnit_i (
    .Funct3M     (Funct3M),
    .adrLow      (IEUAdrM[1:0]),
    .BigEndianM  (BigEndianM),
    .WriteDataM  (WriteDataM),
    .rawReadWord (rawReadWord),
    .storeWord   (storeWord),
    .byteMask    (byteMask),
    .loadData    (loadData)
  );

  ////////////////////
  // M to W register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!StallW) begin
      ReadDataW <= loadData;
    end
  end

endmodule

// ==== hdl/lsuPkg.sv ====
package lsuPkg;

  ////////////////////
  // widths
  ////////////////////

  // the core, the load path and the AHB data bus all share one width
  localparam int xLen = 32;

  typedef logic [xLen-1:0]   wordT;
  typedef logic [xLen-1:0]   adrT;
  typedef logic [xLen/8-1:0] byteMaskT;

  // bit 1 requests a read and bit 0 requests a write
  typedef logic [1:0] memRwT;

  // low two bits give the size, bit 2 asks for zero extension on loads
  typedef logic [2:0] funct3T;

  ////////////////////
  // memory map
  ////////////////////

  // the data TIM sits at the bottom of the address space
  localparam adrT dtimBase    = 32'h0000_0000;
  localparam int  dtimWords   = 256;
  localparam int  dtimAdrBits = 8;

  // uncached region reached over AHB-Lite
  localparam adrT busBase = 32'h8000_0000;
  localparam int  busSpan = 4096;

  ////////////////////
  // encodings
  ////////////////////

  localparam memRwT memNone  = 2'b00;
  localparam memRwT memWrite = 2'b01;
  localparam memRwT memRead  = 2'b10;

  // only idle and nonseq are ever issued, there are no bursts
  localparam logic [1:0] htransIdle   = 2'b00;
  localparam logic [1:0] htransNonseq = 2'b10;

  // states of the single-transfer bus master
  typedef enum logic [1:0] {
    Idle,
    Data,
    Done
  } busStateT;

endpackage

// ==== hdl/memReqIf.sv ====
`timescale 1ns/1ps

// one memory request from the LSU and the response of the memory port behind it
interface memReqIf;
  import lsuPkg::*;

  memRwT    rw;
  adrT      adr;
  funct3T   size;
  wordT     writeData;
  byteMaskT byteMask;
  wordT     readData;
  logic     stall;

  // the LSU top drives the request side
  modport requester (
    output rw, adr, size, writeData, byteMask,
    input  readData, stall
  );

  // the DTIM never stalls and always accesses a full word with byte enables
  modport dtimPort (
    input  rw, adr, writeData, byteMask,
    output readData
  );

  // the bus master may hold the pipeline while its transfer is in flight
  modport busPort (
    input  rw, adr, size, writeData, byteMask,
    output readData, stall
  );

endinterface

// ==== hdl/subwordUnit.sv ====
`timescale 1ns/1ps

module subwordUnit (
  input  lsuPkg::funct3T   Funct3M,
  input  logic [1:0]       adrLow,
  input  logic             BigEndianM,
  input  lsuPkg::wordT     WriteDataM,
  input  lsuPkg::wordT     rawReadWord,
  output lsuPkg::wordT     storeWord,
  output lsuPkg::byteMaskT byteMask,
  output lsuPkg::wordT     loadData
);
  import lsuPkg::*;

  wordT       replicatedWord;
  wordT       littleEndianWord;
  logic [7:0] selectedByte;
  logic [15:0] selectedHalf;

  // reverse the four bytes of a word
  // the hart works little-endian, so the same swap serves loads and stores
  function automatic wordT swapBytes(input wordT w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  ////////////////////
  // store path
  ////////////////////

  // copy the subword into every lane so the memory only needs the byte mask
  always_comb begin
    unique case (Funct3M[1:0])
      2'b00:   replicatedWord = {4{WriteDataM[7:0]}};
      2'b01:   replicatedWord = {2{WriteDataM[15:0]}};
      default: replicatedWord = WriteDataM;
    endcase
  end

  // swapping after replication keeps each copy in its big-endian lane order
  assign storeWord = BigEndianM ? swapBytes(replicatedWord) : replicatedWord;

  // enable only the lanes the access touches
  always_comb begin
    unique case (Funct3M[1:0])
      2'b00:   byteMask = byteMaskT'(4'b0001 << adrLow);
      2'b01:   byteMask = adrLow[1] ? 4'b1100 : 4'b0011;
      default: byteMask = 4'b1111;
    endcase
  end

  ////////////////////
  // load path
  ////////////////////

  // bring the raw word back into little-endian order before picking lanes
  assign littleEndianWord = BigEndianM ? swapBytes(rawReadWord) : rawReadWord;

  // the addressed byte
  always_comb begin
    unique case (adrLow)
      2'b00:   selectedByte = littleEndianWord[7:0];
      2'b01:   selectedByte = littleEndianWord[15:8];
      2'b10:   selectedByte = littleEndianWord[23:16];
      default: selectedByte = littleEndianWord[31:24];
    endcase
  end

  // half accesses are aligned, so only bit 1 of the address matters
  assign selectedHalf = adrLow[1] ? littleEndianWord[31:16] : littleEndianWord[15:0];

  // funct3 bit 2 distinguishes lbu and lhu from lb and lh
  always_comb begin
    unique case (Funct3M[1:0])
      2'b00: begin
        if (Funct3M[2]) begin
          loadData = {24'b0, selectedByte};
        end else begin
          loadData = {{24{selectedByte[7]}}, selectedByte};
        end
      end
      2'b01: begin
        if (Funct3M[2]) begin
          loadData = {16'b0, selectedHalf};
        end else begin
          loadData = {{16{selectedHalf[15]}}, selectedHalf};
        end
      end
      default: loadData = littleEndianWord;
    endcase
  end

endmodule
